// ==== mem_stage_pkg.sv ====
package mem_stage_pkg;

   ////////////////////////////////////////
   // Data path and memory geometry.
   ////////////////////////////////////////

   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 12;
   localparam int RAM_DEPTH = 1024;
   localparam int WORD_AW   = 10;
   localparam int NB_LANE   = 4;

   // Register file index and dirty counter.
   localparam int REG_IDX_W = 5;
   localparam int CNT_W     = 11;

   // Debug register block.
   localparam int APB_AW    = 4;

   ////////////////////////////////////////
   // Load and store access sizes.
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      MS_BYTE   = 3'd0,
      MS_HALF   = 3'd1,
      MS_WORD   = 3'd2,
      MS_BYTE_U = 3'd3,
      MS_HALF_U = 3'd4
   } mem_size_e;

   // APB register offsets of the debug block.
   typedef enum logic [APB_AW-1:0] {
      DBG_CTRL   = 4'd0,
      DBG_ADDR   = 4'd4,
      DBG_RDATA  = 4'd8,
      DBG_STATUS = 4'd12
   } dbg_reg_e;

endpackage

// ==== store_align.sv ====
`timescale 1ns/1ns

module store_align
   import mem_stage_pkg::*;
(
   input  logic                i_mem_write,
   input  mem_size_e           i_mem_size,
   input  logic [1:0]          i_byte_off,
   input  logic [DATA_W-1:0]   i_data,
   output logic [NB_LANE-1:0]  o_lane_we,
   output logic [DATA_W-1:0]   o_data
);

   logic [NB_LANE-1:0] lane_sel;

   // Narrow stores are replicated so every lane already holds the value.
   always_comb begin
      o_data   = i_data;
      lane_sel = '1;
      case (i_mem_size)
         MS_BYTE, MS_BYTE_U: begin
            o_data   = {NB_LANE{i_data[7:0]}};
            lane_sel = {{(NB_LANE-1){1'b0}}, 1'b1} << i_byte_off;
         end
         MS_HALF, MS_HALF_U: begin
            o_data = {2{i_data[15:0]}};
            if (i_byte_off[1]) begin
               lane_sel = 4'b1100;
            end
            else begin
               lane_sel = 4'b0011;
            end
         end
         default: begin
            // Word store, offset bits ignored.
            lane_sel = '1;
         end
      endcase
   end

   assign o_lane_we = i_mem_write ? lane_sel : '0;

endmodule

// ==== load_align.sv ====
`timescale 1ns/1ns

module load_align
   import mem_stage_pkg::*;
(
   input  logic [DATA_W-1:0]  i_word,
   input  mem_size_e          i_mem_size,
   input  logic [1:0]         i_byte_off,
   output logic [DATA_W-1:0]  o_data
);

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;

   ////////////////////////////////////////
   // Lane selection.
   ////////////////////////////////////////

   assign byte_sel = i_word[i_byte_off*8 +: 8];
   assign half_sel = i_byte_off[1] ? i_word[31:16] : i_word[15:0];

   ////////////////////////////////////////
   // Sign or zero extension.
   ////////////////////////////////////////

   always_comb begin
      case (i_mem_size)
         MS_BYTE: begin
            o_data = {{(DATA_W-8){byte_sel[7]}}, byte_sel};
         end
         MS_BYTE_U: begin
            o_data = {{(DATA_W-8){1'b0}}, byte_sel};
         end
         MS_HALF: begin
            o_data = {{(DATA_W-16){half_sel[15]}}, half_sel};
         end
         MS_HALF_U: begin
            o_data = {{(DATA_W-16){1'b0}}, half_sel};
         end
         default: begin
            o_data = i_word;
         end
      endcase
   end

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ns

module data_ram
   import mem_stage_pkg::*;
(
   input  logic                i_clock,
   input  logic [WORD_AW-1:0]  i_addr,
   input  logic [NB_LANE-1:0]  i_lane_we,
   input  logic [DATA_W-1:0]   i_data,
   output logic [DATA_W-1:0]   o_data
);

   logic [DATA_W-1:0] mem [RAM_DEPTH];

   ////////////////////////////////////////
   // Byte-lane write port.
   ////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      for (int lane = 0; lane < NB_LANE; lane++) begin
         if (i_lane_we[lane]) begin
            mem[i_addr][lane*8 +: 8] <= i_data[lane*8 +: 8];
         end
      end
   end

   // Low latency read without an output register.
   assign o_data = mem[i_addr];

endmodule

// ==== dirty_tracker.sv ====
`timescale 1ns/1ns

module dirty_tracker
   import mem_stage_pkg::*;
(
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  logic [WORD_AW-1:0]  i_addr,
   input  logic                i_write,
   input  logic                i_clear,
   output logic [CNT_W-1:0]    o_dirty_count,
   output logic                o_any_dirty
);

   logic [RAM_DEPTH-1:0] dirty_bits;

   // One bit per word; the count only moves on the first write to a word.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset || i_clear) begin
         dirty_bits    <= '0;
         o_dirty_count <= '0;
         o_any_dirty   <= 1'b0;
      end
      else if (i_write) begin
         o_any_dirty <= 1'b1;
         if (!dirty_bits[i_addr]) begin
            dirty_bits[i_addr] <= 1'b1;
            o_dirty_count      <= o_dirty_count + 1'b1;
         end
      end
   end

   a_count_bounded : assert property (
      @(posedge i_clock) disable iff (!i_soft_reset)
      o_dirty_count <= CNT_W'(RAM_DEPTH)
   );

endmodule

// ==== mem_debug_regs.sv ====
`timescale 1ns/1ns

module mem_debug_regs
   import mem_stage_pkg::*;
(
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  logic                i_psel,
   input  logic                i_penable,
   input  logic                i_pwrite,
   input  logic [APB_AW-1:0]   i_paddr,
   input  logic [DATA_W-1:0]   i_pwdata,
   input  logic [DATA_W-1:0]   i_debug_word,
   input  logic [CNT_W-1:0]    i_dirty_count,
   input  logic                i_any_dirty,
   output logic [DATA_W-1:0]   o_prdata,
   output logic                o_debug_mode,
   output logic [ADDR_W-1:0]   o_debug_addr,
   output logic                o_dirty_clear
);

   dbg_reg_e          reg_sel;
   logic              wr_en;
   logic [DATA_W-1:0] status_word;

   assign reg_sel = dbg_reg_e'(i_paddr);
   assign wr_en   = i_psel && i_penable && i_pwrite;

   ////////////////////////////////////////
   // Register writes.
   ////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_debug_mode  <= 1'b0;
         o_debug_addr  <= '0;
         o_dirty_clear <= 1'b0;
      end
      else begin
         o_dirty_clear <= 1'b0;
         if (wr_en && reg_sel == DBG_CTRL) begin
            o_debug_mode  <= i_pwdata[0];
            o_dirty_clear <= i_pwdata[1];
         end
         if (wr_en && reg_sel == DBG_ADDR) begin
            o_debug_addr <= i_pwdata[ADDR_W-1:0];
         end
      end
   end

   ////////////////////////////////////////
   // Read mux.
   ////////////////////////////////////////

   always_comb begin
      status_word              = '0;
      status_word[16]          = i_any_dirty;
      status_word[CNT_W-1:0]   = i_dirty_count;
   end

   always_comb begin
      o_prdata = '0;
      if (i_psel) begin
         case (reg_sel)
            DBG_CTRL:   o_prdata = {{(DATA_W-1){1'b0}}, o_debug_mode};
            DBG_ADDR:   o_prdata = {{(DATA_W-ADDR_W){1'b0}}, o_debug_addr};
            DBG_RDATA:  o_prdata = i_debug_word;
            DBG_STATUS: o_prdata = status_word;
            default:    o_prdata = '0;
         endcase
      end
   end

   a_penable_needs_psel : assert property (
      @(posedge i_clock) disable iff (!i_soft_reset) i_penable |-> i_psel
   );

endmodule

// ==== mem_access.sv ====
`timescale 1ns/1ns

module mem_access
   import mem_stage_pkg::*;
(
   input  logic                  i_clock,
   input  logic                  i_soft_reset,
   input  logic                  i_enable_pipeline,
   input  logic                  i_debug_mode,
   input  logic [ADDR_W-1:0]     i_debug_addr,
   input  logic [DATA_W-1:0]     i_address_alu,
   input  logic                  i_mem_read,
   input  logic [NB_LANE-1:0]    i_lane_we_pipe,
   input  logic [DATA_W-1:0]     i_load_data,
   input  logic                  i_reg_write,
   input  logic                  i_mem_to_reg,
   input  logic [REG_IDX_W-1:0]  i_reg_dest,
   input  logic                  i_halt_detected,
   output logic [WORD_AW-1:0]    o_ram_addr,
   output logic [1:0]            o_byte_off,
   output logic [NB_LANE-1:0]    o_lane_we,
   output logic                  o_reg_write,
   output logic                  o_mem_to_reg,
   output logic [REG_IDX_W-1:0]  o_reg_dest,
   output logic                  o_halt_detected,
   output logic [DATA_W-1:0]     o_data_alu,
   output logic [DATA_W-1:0]     o_data_mem
);

   logic [ADDR_W-1:0] mem_addr;

   ////////////////////////////////////////
   // Address and write steering.
   ////////////////////////////////////////

   assign mem_addr   = i_debug_mode ? i_debug_addr : i_address_alu[ADDR_W-1:0];
   assign o_ram_addr = mem_addr[ADDR_W-1 -: WORD_AW];
   assign o_byte_off = mem_addr[1:0];

   // Pipeline writes are frozen while debug owns the address.
   assign o_lane_we = (i_enable_pipeline && !i_debug_mode) ? i_lane_we_pipe : '0;

   ////////////////////////////////////////
   // MEM/WB register.
   ////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write     <= 1'b0;
         o_mem_to_reg    <= 1'b0;
         o_reg_dest      <= '0;
         o_halt_detected <= 1'b0;
         o_data_alu      <= '0;
         o_data_mem      <= '0;
      end
      else if (i_enable_pipeline) begin
         o_reg_write     <= i_reg_write;
         o_mem_to_reg    <= i_mem_to_reg;
         o_reg_dest      <= i_reg_dest;
         o_halt_detected <= i_halt_detected;
         o_data_alu      <= i_address_alu;
         o_data_mem      <= i_mem_read ? i_load_data : '0;
      end
   end

endmodule

// ==== mem_stage_top.sv ====
`timescale 1ns/1ns

module mem_stage_top
   import mem_stage_pkg::*;
(
   input  logic                  i_clock,
   input  logic                  i_soft_reset,
   // Pipeline side.
   input  logic [DATA_W-1:0]     i_address_alu,
   input  logic [DATA_W-1:0]     i_data_write_mem,
   input  logic                  i_mem_read,
   input  logic                  i_mem_write,
   input  mem_size_e             i_mem_size,
   input  logic                  i_reg_write,
   input  logic                  i_mem_to_reg,
   input  logic [REG_IDX_W-1:0]  i_reg_dest,
   input  logic                  i_halt_detected,
   input  logic                  i_enable_pipeline,
   output logic                  o_reg_write,
   output logic                  o_mem_to_reg,
   output logic [REG_IDX_W-1:0]  o_reg_dest,
   output logic                  o_halt_detected,
   output logic [DATA_W-1:0]     o_data_alu,
   output logic [DATA_W-1:0]     o_data_mem,
   // Debug unit APB side.
   input  logic                  i_psel,
   input  logic                  i_penable,
   input  logic                  i_pwrite,
   input  logic [APB_AW-1:0]     i_paddr,
   input  logic [DATA_W-1:0]     i_pwdata,
   output logic [DATA_W-1:0]     o_prdata
);

   logic [WORD_AW-1:0] ram_addr;
   logic [1:0]         byte_off;
   logic [NB_LANE-1:0] pipe_lane_we;
   logic [NB_LANE-1:0] ram_lane_we;
   logic [DATA_W-1:0]  store_data;
   logic [DATA_W-1:0]  ram_word;
   logic [DATA_W-1:0]  load_data;
   logic               debug_mode;
   logic [ADDR_W-1:0]  debug_addr;
   logic               dirty_clear;
   logic [CNT_W-1:0]   dirty_count;
   logic               any_dirty;

   store_align u_store_align (
      .i_mem_write (i_mem_write),
      .i_mem_size  (i_mem_size),
      .i_byte_off  (byte_off),
      .i_data      (i_data_write_mem),
      .o_lane_we   (pipe_lane_we),
      .o_data      (store_data)
   );

   mem_access u_mem_access (
      .i_clock           (i_clock),
      .i_soft_reset      (i_soft_reset),
      .i_enable_pipeline (i_enable_pipeline),
      .i_debug_mode      (debug_mode),
      .i_debug_addr      (debug_addr),
      .i_address_alu     (i_address_alu),
      .i_mem_read        (i_mem_read),
      .i_lane_we_pipe    (pipe_lane_we),
      .i_load_data       (load_data),
      .i_reg_write       (i_reg_write),
      .i_mem_to_reg      (i_mem_to_reg),
      .i_reg_dest        (i_reg_dest),
      .i_halt_detected   (i_halt_detected),
      .o_ram_addr        (ram_addr),
      .o_byte_off        (byte_off),
      .o_lane_we         (ram_lane_we),
      .o_reg_write       (o_reg_write),
      .o_mem_to_reg      (o_mem_to_reg),
      .o_reg_dest        (o_reg_dest),
      .o_halt_detected   (o_halt_detected),
      .o_data_alu        (o_data_alu),
      .o_data_mem        (o_data_mem)
   );

   data_ram u_data_ram (
      .i_clock   (i_clock),
      .i_addr    (ram_addr),
      .i_lane_we (ram_lane_we),
      .i_data    (store_data),
      .o_data    (ram_word)
   );

   load_align u_load_align (
      .i_word     (ram_word),
      .i_mem_size (i_mem_size),
      .i_byte_off (byte_off),
      .o_data     (load_data)
   );

   dirty_tracker u_dirty_tracker (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_addr        (ram_addr),
      .i_write       (|ram_lane_we),
      .i_clear       (dirty_clear),
      .o_dirty_count (dirty_count),
      .o_any_dirty   (any_dirty)
   );

   mem_debug_regs u_mem_debug_regs (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_psel        (i_psel),
      .i_penable     (i_penable),
      .i_pwrite      (i_pwrite),
      .i_paddr       (i_paddr),
      .i_pwdata      (i_pwdata),
      .i_debug_word  (ram_word),
      .i_dirty_count (dirty_count),
      .i_any_dirty   (any_dirty),
      .o_prdata      (o_prdata),
      .o_debug_mode  (debug_mode),
      .o_debug_addr  (debug_addr),
      .o_dirty_clear (dirty_clear)
   );

endmodule

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage
   import mem_stage_pkg::*;
();

   localparam int NUM_RANDOM     = 1500;
   localparam int TIMEOUT_CYCLES = 4000;

   // Expected MEM/WB contents for one captured cycle.
   typedef struct packed {
      logic [DATA_W-1:0]    alu;
      logic [DATA_W-1:0]    mem;
      logic                 rw;
      logic                 m2r;
      logic [REG_IDX_W-1:0] dest;
      logic                 halt;
   } exp_t;

   logic                 i_clock;
   logic                 i_soft_reset;
   logic [DATA_W-1:0]    i_address_alu;
   logic [DATA_W-1:0]    i_data_write_mem;
   logic                 i_mem_read;
   logic                 i_mem_write;
   mem_size_e            i_mem_size;
   logic                 i_reg_write;
   logic                 i_mem_to_reg;
   logic [REG_IDX_W-1:0] i_reg_dest;
   logic                 i_halt_detected;
   logic                 i_enable_pipeline;
   logic                 o_reg_write;
   logic                 o_mem_to_reg;
   logic [REG_IDX_W-1:0] o_reg_dest;
   logic                 o_halt_detected;
   logic [DATA_W-1:0]    o_data_alu;
   logic [DATA_W-1:0]    o_data_mem;
   logic                 i_psel;
   logic                 i_penable;
   logic                 i_pwrite;
   logic [APB_AW-1:0]    i_paddr;
   logic [DATA_W-1:0]    i_pwdata;
   logic [DATA_W-1:0]    o_prdata;

   // Reference model state.
   logic [DATA_W-1:0]  ref_mem [RAM_DEPTH];
   logic               dirty_ref [RAM_DEPTH];
   logic [CNT_W-1:0]   cnt_ref;
   logic               any_ref;
   logic               dbg_mode_ref;
   logic [ADDR_W-1:0]  dbg_addr_ref;
   logic [WORD_AW-1:0] pool [16];
   exp_t               exp_q [$];
   exp_t               last_exp;
   logic [31:0]        lfsr_state = 32'h5641;
   int                 err_count = 0;
   int                 num_checks = 0;
   int                 cycle_count = 0;

   mem_stage_top u_dut (.*);

   initial begin
      i_clock = 1'b0;
      forever #50 i_clock = ~i_clock;
   end

   always @(posedge i_clock) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
         $display("TB FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Random numbers and reference rules.
   ////////////////////////////////////////

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic mem_size_e pick_size();
      logic [2:0] v;
      v = 3'(rand_bits(3) % 5);
      return mem_size_e'(v);
   endfunction

   function automatic logic [DATA_W-1:0] store_merge(input logic [DATA_W-1:0] old_word,
         input logic [DATA_W-1:0] data, input mem_size_e size, input logic [1:0] off);
      logic [DATA_W-1:0] w;
      w = old_word;
      if (size == MS_WORD) begin
         w = data;
      end
      else if (size == MS_HALF || size == MS_HALF_U) begin
         w[off[1]*16 +: 16] = data[15:0];
      end
      else begin
         w[off*8 +: 8] = data[7:0];
      end
      return w;
   endfunction

   function automatic logic [DATA_W-1:0] load_extend(input logic [DATA_W-1:0] word,
         input mem_size_e size, input logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[off*8 +: 8];
      h = word[off[1]*16 +: 16];
      case (size)
         MS_BYTE:   return DATA_W'($signed(b));
         MS_BYTE_U: return DATA_W'(b);
         MS_HALF:   return DATA_W'($signed(h));
         MS_HALF_U: return DATA_W'(h);
         default:   return word;
      endcase
   endfunction

   ////////////////////////////////////////
   // Compare tasks.
   ////////////////////////////////////////

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
                             input string what);
      num_checks++;
      if (got !== want) begin
         err_count++;
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic check_ctrl(input logic rw, input logic m2r, input logic [REG_IDX_W-1:0] dest,
                             input logic halt, input exp_t want);
      num_checks++;
      if ({rw, m2r, dest, halt} !== {want.rw, want.m2r, want.dest, want.halt}) begin
         err_count++;
         $display("[ERROR] %0t ns: control is %b/%b/%0d/%b, expected %b/%b/%0d/%b", $time,
                  rw, m2r, dest, halt, want.rw, want.m2r, want.dest, want.halt);
      end
   endtask

   task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] want,
                              input string what);
      num_checks++;
      if (got !== want) begin
         err_count++;
         $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
      end
   endtask

   ////////////////////////////////////////
   // APB and pipeline drivers.
   ////////////////////////////////////////

   task automatic apb_access(input dbg_reg_e offs, input logic wr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
      @(posedge i_clock);
      #10;
      // The pipeline idles while the debug unit talks.
      i_enable_pipeline = 1'b0;
      i_mem_write = 1'b0;
      i_mem_read = 1'b0;
      i_psel = 1'b1;
      i_penable = 1'b0;
      i_pwrite = wr;
      i_paddr = offs;
      i_pwdata = wdata;
      @(posedge i_clock);
      #10;
      i_penable = 1'b1;
      #40;
      rdata = o_prdata;
      @(posedge i_clock);
      #10;
      i_psel = 1'b0;
      i_penable = 1'b0;
      i_pwrite = 1'b0;
   endtask

   task automatic apb_write(input dbg_reg_e offs, input logic [DATA_W-1:0] wdata);
      logic [DATA_W-1:0] unused;
      apb_access(offs, 1'b1, wdata, unused);
   endtask

   task automatic verify_status();
      logic [DATA_W-1:0] rdata;
      apb_access(DBG_STATUS, 1'b0, '0, rdata);
      check_count(rdata[CNT_W-1:0], cnt_ref, "dirty count");
      check_word(rdata, {{(DATA_W-17){1'b0}}, any_ref, {(16-CNT_W){1'b0}}, cnt_ref},
                 "DBG_STATUS");
   endtask

   task automatic clear_dirty();
      apb_write(DBG_CTRL, {{(DATA_W-2){1'b0}}, 1'b1, dbg_mode_ref});
      foreach (dirty_ref[k]) begin
         dirty_ref[k] = 1'b0;
      end
      cnt_ref = '0;
      any_ref = 1'b0;
   endtask

   task automatic drive_txn(input logic en, input logic rd, input logic wr,
                            input logic [WORD_AW-1:0] idx, input logic [1:0] off,
                            input mem_size_e size, input logic [DATA_W-1:0] wdata);
      logic [DATA_W-1:0]  addr;
      logic [WORD_AW-1:0] eff_idx;
      logic [1:0]         eff_off;
      exp_t               e;
      addr = rand_bits(DATA_W);
      addr[ADDR_W-1:0] = {idx, off};
      @(posedge i_clock);
      #10;
      i_enable_pipeline = en;
      i_mem_read = rd;
      i_mem_write = wr;
      i_mem_size = size;
      i_address_alu = addr;
      i_data_write_mem = wdata;
      i_reg_write = 1'(rand_bits(1));
      i_mem_to_reg = 1'(rand_bits(1));
      i_reg_dest = REG_IDX_W'(rand_bits(REG_IDX_W));
      i_halt_detected = 1'(rand_bits(1));
      // Debug mode moves the RAM address to DBG_ADDR.
      eff_idx = dbg_mode_ref ? dbg_addr_ref[ADDR_W-1:2] : idx;
      eff_off = dbg_mode_ref ? dbg_addr_ref[1:0] : off;
      if (en) begin
         e.alu = addr;
         e.mem = rd ? load_extend(ref_mem[eff_idx], size, eff_off) : '0;
         e.rw = i_reg_write;
         e.m2r = i_mem_to_reg;
         e.dest = i_reg_dest;
         e.halt = i_halt_detected;
         last_exp = e;
         if (wr && !dbg_mode_ref) begin
            ref_mem[idx] = store_merge(ref_mem[idx], wdata, size, off);
            any_ref = 1'b1;
            if (!dirty_ref[idx]) begin
               dirty_ref[idx] = 1'b1;
               cnt_ref = cnt_ref + 1'b1;
            end
         end
      end
      exp_q.push_back(last_exp);
   endtask

   // Checks the MEM/WB outputs one edge after each driven cycle.
   initial begin
      exp_t e;
      forever begin
         @(posedge i_clock);
         #5;
         if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_word(o_data_alu, e.alu, "o_data_alu");
            check_word(o_data_mem, e.mem, "o_data_mem");
            check_ctrl(o_reg_write, o_mem_to_reg, o_reg_dest, o_halt_detected, e);
         end
      end
   end

   ////////////////////////////////////////
   // Test sequence.
   ////////////////////////////////////////

   initial begin
      logic [DATA_W-1:0] rdata;
      logic [1:0]        op;
      i_soft_reset = 1'b0;
      i_address_alu = '0;
      i_data_write_mem = '0;
      i_mem_read = 1'b0;
      i_mem_write = 1'b0;
      i_mem_size = MS_BYTE;
      i_reg_write = 1'b0;
      i_mem_to_reg = 1'b0;
      i_reg_dest = '0;
      i_halt_detected = 1'b0;
      i_enable_pipeline = 1'b0;
      i_psel = 1'b0;
      i_penable = 1'b0;
      i_pwrite = 1'b0;
      i_paddr = '0;
      i_pwdata = '0;
      cnt_ref = '0;
      any_ref = 1'b0;
      dbg_mode_ref = 1'b0;
      dbg_addr_ref = '0;
      last_exp = '0;
      foreach (dirty_ref[k]) begin
         dirty_ref[k] = 1'b0;
      end
      repeat (16) @(posedge i_clock);
      #10;
      i_soft_reset = 1'b1;

      check_word(o_data_alu, '0, "o_data_alu after reset");
      check_word(o_data_mem, '0, "o_data_mem after reset");
      check_ctrl(o_reg_write, o_mem_to_reg, o_reg_dest, o_halt_detected, last_exp);
      verify_status();

      // Whole words first, so later loads never see unwritten bytes.
      for (int k = 0; k < 16; k++) begin
         pool[k] = WORD_AW'(rand_bits(WORD_AW));
         drive_txn(1'b1, 1'b0, 1'b1, pool[k], 2'(rand_bits(2)), MS_WORD, rand_bits(DATA_W));
      end
      for (int n = 0; n < NUM_RANDOM; n++) begin
         op = 2'(rand_bits(2));
         drive_txn(1'b1, op == 2'd1 || op == 2'd2, op == 2'd0, pool[4'(rand_bits(4))],
                   2'(rand_bits(2)), pick_size(), rand_bits(DATA_W));
      end
      verify_status();

      // Stalled stores must not land.
      repeat (4) begin
         drive_txn(1'b0, 1'b0, 1'b1, pool[0], 2'd0, MS_WORD, rand_bits(DATA_W));
      end
      drive_txn(1'b1, 1'b1, 1'b0, pool[0], 2'd0, MS_WORD, '0);

      dbg_addr_ref = {pool[3], 2'b00};
      apb_write(DBG_ADDR, DATA_W'(dbg_addr_ref));
      apb_write(DBG_CTRL, 32'h1);
      dbg_mode_ref = 1'b1;
      apb_access(DBG_RDATA, 1'b0, '0, rdata);
      check_word(rdata, ref_mem[pool[3]], "DBG_RDATA");
      drive_txn(1'b1, 1'b0, 1'b1, pool[4], 2'd0, MS_WORD, rand_bits(DATA_W));
      drive_txn(1'b1, 1'b1, 1'b0, pool[5], 2'd0, MS_WORD, '0);
      apb_write(DBG_CTRL, 32'h0);
      dbg_mode_ref = 1'b0;
      drive_txn(1'b1, 1'b1, 1'b0, pool[4], 2'd0, MS_WORD, '0);

      // Five distinct words, two of them written twice.
      clear_dirty();
      verify_status();
      for (int k = 0; k < 7; k++) begin
         drive_txn(1'b1, 1'b0, 1'b1, WORD_AW'(10'h200 + k % 5), 2'(k), pick_size(),
                   rand_bits(DATA_W));
      end
      verify_status();
      clear_dirty();
      verify_status();

      while (exp_q.size() > 0) begin
         @(posedge i_clock);
      end
      #20;
      $display("Checks run: %0d, errors: %0d", num_checks, err_count);
      if (err_count == 0) begin
         $display("TB PASSED");
      end
      else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
mem_stage_pkg.sv
store_align.sv
load_align.sv
data_ram.sv
dirty_tracker.sv
mem_debug_regs.sv
mem_access.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_mem_stage \
   -f compile.f \
   -o tb_mem_stage

./obj_dir/tb_mem_stage | tee sim.log

if grep -q "TB FAILED" sim.log; then
   echo "Simulation reported a failure."
   exit 1
fi

echo "Simulation finished without failures."
